// File: sources.f
+incdir+include
verilog/julia_pkg.sv
verilog/julia_config_regs.sv
verilog/pixel_dispatch.sv
verilog/julia_worker.sv
verilog/mask_gen.sv
verilog/search.sv
verilog/julia_farm.sv
tests/julia_checker.sv
tests/julia_farm_tb.sv

// File: tests/julia_farm_tb.sv
`include "julia_config.svh"

module julia_farm_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ROWS = 5;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLE_LIMIT =
		NUM_ROWS * `JULIA_IMG_W * `JULIA_IMG_H * (`JULIA_MAX_ITER + 4) + RESET_CYCLES;

	typedef struct packed {
		logic [15:0] c_re;
		logic [15:0] c_im;
		logic        try_busy;
		logic        inside_max;
		logic        never_max;
	} row_t;

	logic clk;
	logic n_rst;
	logic cfg_we;
	logic [1:0] cfg_addr;
	logic [15:0] cfg_wdata;
	logic pixel_we;
	julia_pkg::address_t pixel_addr;
	julia_pkg::pixel_t pixel_data;
	logic busy;

	row_t rows [NUM_ROWS];
	julia_pkg::coord_t cur_re;
	julia_pkg::coord_t cur_im;
	logic cur_inside_max;
	logic cur_never_max;
	int starts_issued;
	int error_count;
	int frame_count;
	int write_count;
	int cycle_count;
	logic [31:0] lfsr_state;
	logic [15:0] rnd_re;
	logic [15:0] rnd_im;

	julia_farm UUT (
		.clk(clk),
		.n_rst(n_rst),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.pixel_we(pixel_we),
		.pixel_addr(pixel_addr),
		.pixel_data(pixel_data),
		.busy(busy)
	);

	julia_checker pixel_check (
		.clk(clk),
		.n_rst(n_rst),
		.pixel_we(pixel_we),
		.pixel_addr(pixel_addr),
		.pixel_data(pixel_data),
		.busy(busy),
		.c_re(cur_re),
		.c_im(cur_im),
		.inside_max(cur_inside_max),
		.never_max(cur_never_max),
		.starts_issued(starts_issued),
		.error_count(error_count),
		.frame_count(frame_count),
		.write_count(write_count)
	);

	// galois form with taps 32 30 26 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'hA300_0000 : 32'h0);
	endfunction

	// 13 random bits sign extended give -1.0 up to just under 1.0
	task automatic draw_coord(output logic [15:0] v);
		logic [12:0] bits;
		bits = '0;
		for (int i = 0; i < 13; i++) begin
			bits = {bits[11:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		v = {{3{bits[12]}}, bits};
	endtask

	// one register write held for a single cycle
	task automatic write_reg(input logic [1:0] a, input logic [15:0] d);
		@(negedge clk);
		cfg_we = 1'b1;
		cfg_addr = a;
		cfg_wdata = d;
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// run limit in cycles
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout, run still going after %0d cycles", cycle_count);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		n_rst = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		cur_re = '0;
		cur_im = '0;
		cur_inside_max = 1'b0;
		cur_never_max = 1'b0;
		starts_issued = 0;
		lfsr_state = 32'h4429b626;
		// fixed rows use c = 0 then 1.5+1.5i then -0.8+0.156i
		rows[0] = '{16'h0000, 16'h0000, 1'b0, 1'b1, 1'b0};
		rows[1] = '{16'h1800, 16'h1800, 1'b0, 1'b0, 1'b1};
		rows[2] = '{16'hF334, 16'h027F, 1'b1, 1'b0, 1'b0};
		draw_coord(rnd_re);
		draw_coord(rnd_im);
		rows[3] = '{rnd_re, rnd_im, 1'b1, 1'b0, 1'b0};
		draw_coord(rnd_re);
		draw_coord(rnd_im);
		rows[4] = '{rnd_re, rnd_im, 1'b0, 1'b0, 1'b0};
		repeat (RESET_CYCLES) @(negedge clk);
		n_rst = 1'b1;
		repeat (4) @(negedge clk);
		for (int r = 0; r < NUM_ROWS; r++) begin
			cur_re = rows[r].c_re;
			cur_im = rows[r].c_im;
			cur_inside_max = rows[r].inside_max;
			cur_never_max = rows[r].never_max;
			write_reg(2'd0, rows[r].c_re);
			write_reg(2'd1, rows[r].c_im);
			starts_issued++;
			write_reg(2'd2, 16'h0000);
			while (!busy)
				@(negedge clk);
			// c and start while busy must be dropped
			if (rows[r].try_busy) begin
				write_reg(2'd0, ~rows[r].c_re);
				write_reg(2'd1, ~rows[r].c_im);
				write_reg(2'd2, 16'h0000);
			end
			while (busy)
				@(negedge clk);
			// a stray frame would show up here
			repeat (8) @(negedge clk);
		end
		$display("errors: %0d, frames: %0d of %0d, pixel writes: %0d",
			error_count, frame_count, starts_issued, write_count);
		if (error_count == 0 && frame_count == NUM_ROWS)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: tests/julia_checker.sv
`include "julia_config.svh"

module julia_checker (
	input  logic                clk,
	input  logic                n_rst,
	input  logic                pixel_we,
	input  julia_pkg::address_t pixel_addr,
	input  julia_pkg::pixel_t   pixel_data,
	input  logic                busy,
	input  julia_pkg::coord_t   c_re,
	input  julia_pkg::coord_t   c_im,
	input  logic                inside_max,
	input  logic                never_max,
	input  int                  starts_issued,
	output int                  error_count,
	output int                  frame_count,
	output int                  write_count
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_PIXELS = `JULIA_IMG_W * `JULIA_IMG_H;

	bit seen [NUM_PIXELS];
	logic prev_busy;
	logic reset_checked;
	int expected;
	julia_pkg::coord_t px_re;
	julia_pkg::coord_t px_im;

	// escape count from z0 iterating z*z + c in Q4.12
	function automatic int escape_count(input julia_pkg::coord_t z0_re,
			input julia_pkg::coord_t z0_im, input julia_pkg::coord_t cr,
			input julia_pkg::coord_t ci);
		julia_pkg::coord_t zr;
		julia_pkg::coord_t zi;
		int sq_re;
		int sq_im;
		int prod;
		int n;
		bit out;
		zr = z0_re;
		zi = z0_im;
		n = 0;
		out = 1'b0;
		while (n < `JULIA_MAX_ITER && !out) begin
			sq_re = (int'(zr) * int'(zr)) >>> `JULIA_FRAC_BITS;
			sq_im = (int'(zi) * int'(zi)) >>> `JULIA_FRAC_BITS;
			prod  = (int'(zr) * int'(zi)) >>> `JULIA_FRAC_BITS;
			// |z|^2 above 4.0 ends the run before stepping
			if (sq_re + sq_im > (4 << `JULIA_FRAC_BITS)) begin
				out = 1'b1;
			end else begin
				zr = julia_pkg::coord_t'(sq_re - sq_im + int'(cr));
				zi = julia_pkg::coord_t'(2 * prod + int'(ci));
				n++;
			end
		end
		return n;
	endfunction

	initial begin
		error_count = 0;
		frame_count = 0;
		write_count = 0;
		prev_busy = 1'b0;
		reset_checked = 1'b0;
	end

	always @(posedge clk) begin
		if (n_rst) begin
			// idle outputs right after reset
			if (!reset_checked) begin
				reset_checked = 1'b1;
				if (pixel_we !== 1'b0) begin
					$display("Error: pixel_we after reset expected 0x0 actual 0x%h", pixel_we);
					error_count++;
				end
				if (busy !== 1'b0) begin
					$display("Error: busy after reset expected 0x0 actual 0x%h", busy);
					error_count++;
				end
			end
			// new frame allowed only after a start write
			if (busy && !prev_busy) begin
				frame_count++;
				foreach (seen[a])
					seen[a] = 1'b0;
				if (frame_count > starts_issued) begin
					$display("frame %0d began without a start write", frame_count);
					error_count++;
				end
			end
			if (pixel_we) begin
				write_count++;
				if (!busy) begin
					$display("pixel write to address %0d while not busy", pixel_addr);
					error_count++;
				end else if (pixel_addr >= NUM_PIXELS) begin
					$display("pixel write to address %0d outside the frame", pixel_addr);
					error_count++;
				end else if (seen[pixel_addr]) begin
					$display("second write to address %0d in one frame", pixel_addr);
					error_count++;
				end else begin
					seen[pixel_addr] = 1'b1;
					// plane point of this pixel
					px_re = julia_pkg::coord_t'(`JULIA_X0
						+ int'(pixel_addr % `JULIA_IMG_W) * `JULIA_STEP);
					px_im = julia_pkg::coord_t'(`JULIA_Y0
						+ int'(pixel_addr / `JULIA_IMG_W) * `JULIA_STEP);
					expected = escape_count(px_re, px_im, c_re, c_im);
					if (pixel_data !== julia_pkg::pixel_t'(expected)) begin
						$display("Error: pixel_data addr 0x%0h expected 0x%02h actual 0x%02h",
							pixel_addr, expected, pixel_data);
						error_count++;
					end
					// with c = 0 points strictly inside |z| < 1 never leave
					if (inside_max && pixel_data != `JULIA_MAX_ITER
							&& int'(px_re) * int'(px_re) + int'(px_im) * int'(px_im)
							< (1 << (2 * `JULIA_FRAC_BITS))) begin
						$display("Error: pixel_data disc addr 0x%0h expected 0x%02h actual 0x%02h",
							pixel_addr, `JULIA_MAX_ITER, pixel_data);
						error_count++;
					end
					if (never_max && pixel_data == `JULIA_MAX_ITER) begin
						$display("Error: pixel_data addr 0x%0h expected below 0x%02h actual 0x%02h",
							pixel_addr, `JULIA_MAX_ITER, pixel_data);
						error_count++;
					end
				end
			end
			// at frame end every address needs one write
			if (!busy && prev_busy) begin
				foreach (seen[a]) begin
					if (!seen[a]) begin
						$display("no write to address %0d in frame %0d", a, frame_count);
						error_count++;
					end
				end
			end
			prev_busy = busy;
		end
	end

endmodule

// File: verilog/julia_farm.sv
`include "julia_config.svh"

module julia_farm (
	input  logic                clk,
	input  logic                n_rst,
	input  logic                cfg_we,
	input  logic [1:0]          cfg_addr,
	input  logic [15:0]         cfg_wdata,
	output logic                pixel_we,
	output julia_pkg::address_t pixel_addr,
	output julia_pkg::pixel_t   pixel_data,
	output logic                busy
);

	localparam int N = `JULIA_NUM_JULIA;

	julia_pkg::coord_t   c_re;
	julia_pkg::coord_t   c_im;
	logic                frame_start;
	logic [N-1:0]        idle;
	logic [N-1:0]        start;
	logic [N-1:0]        done;
	logic [N-1:0]        grant;
	julia_pkg::coord_t   job_re;
	julia_pkg::coord_t   job_im;
	julia_pkg::address_t job_addr;
	logic [N*32-1:0]     cataddresses;
	logic [N*8-1:0]      catpixels;

	julia_config_regs regs (
		.clk(clk),
		.n_rst(n_rst),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.busy(busy),
		.c_re(c_re),
		.c_im(c_im),
		.frame_start(frame_start)
	);

	// pixel_we doubles as the found count for frame end
	pixel_dispatch dispatch (
		.clk(clk),
		.n_rst(n_rst),
		.frame_start(frame_start),
		.idle(idle),
		.found(pixel_we),
		.start(start),
		.job_re(job_re),
		.job_im(job_im),
		.job_addr(job_addr),
		.busy(busy)
	);

	// workers share the job bus, start picks one
	for (genvar k = 0; k < N; k++) begin : g_worker
		julia_worker worker (
			.clk(clk),
			.n_rst(n_rst),
			.start(start[k]),
			.job_re(job_re),
			.job_im(job_im),
			.job_addr(job_addr),
			.c_re(c_re),
			.c_im(c_im),
			.grant(grant[k]),
			.idle(idle[k]),
			.done(done[k]),
			.address(cataddresses[k*32 +: 32]),
			.pixel(catpixels[k*8 +: 8])
		);
	end

	// mask only matters inside search
	search #(
		.NUM_JULIA(N)
	) srch (
		.clk(clk),
		.n_rst(n_rst),
		.cataddresses(cataddresses),
		.catpixels(catpixels),
		.done(done),
		.found(pixel_we),
		.sel_data_syn(pixel_data),
		.sel_address_syn(pixel_addr),
		.mask(),
		.grant(grant)
	);

endmodule

// File: verilog/search.sv
`include "julia_config.svh"

module search #(
	parameter int NUM_JULIA = `JULIA_NUM_JULIA
) (
	input  logic                    clk,
	input  logic                    n_rst,
	input  logic [NUM_JULIA*32-1:0] cataddresses,
	input  logic [NUM_JULIA*8-1:0]  catpixels,
	input  logic [NUM_JULIA-1:0]    done,
	output logic                    found,
	output julia_pkg::pixel_t       sel_data_syn,
	output julia_pkg::address_t     sel_address_syn,
	output logic [NUM_JULIA-1:0]    mask,
	output logic [NUM_JULIA-1:0]    grant
);

	julia_pkg::pixel_t   sel_data;
	julia_pkg::address_t sel_address;
	logic shift_enable;

	mask_gen #(
		.NUM_JULIA(NUM_JULIA)
	) mg (
		.clk(clk),
		.n_rst(n_rst),
		.shift_enable(shift_enable),
		.mask(mask)
	);

	// mask is one-hot, so at most one worker can match
	always_comb begin
		sel_address  = '0;
		sel_data     = '0;
		grant        = '0;
		shift_enable = 1'b1;
		for (int k = 0; k < NUM_JULIA; k++) begin
			if ((mask & done) == (NUM_JULIA'(1) << k)) begin
				sel_address  = cataddresses[k*32 +: 32];
				sel_data     = catpixels[k*8 +: 8];
				grant[k]     = 1'b1;
				// hold the mask on this worker for the match cycle
				shift_enable = 1'b0;
			end
		end
	end

	// a match becomes a write one cycle later
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			found <= 1'b0;
		else
			found <= ~shift_enable;
	end

	always_ff @(posedge clk) begin
		sel_data_syn    <= sel_data;
		sel_address_syn <= sel_address;
	end

endmodule

// File: verilog/mask_gen.sv
`include "julia_config.svh"

module mask_gen #(
	parameter int NUM_JULIA = `JULIA_NUM_JULIA
) (
	input  logic                 clk,
	input  logic                 n_rst,
	input  logic                 shift_enable,
	output logic [NUM_JULIA-1:0] mask
);

	// one-hot ring starting at worker 0
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			mask <= NUM_JULIA'(1);
		end else if (shift_enable) begin
			// rotate left, top bit wraps to bit 0
			mask <= {mask[NUM_JULIA-2:0], mask[NUM_JULIA-1]};
		end
	end

endmodule

// File: verilog/julia_worker.sv
`include "julia_config.svh"

module julia_worker (
	input  logic                clk,
	input  logic                n_rst,
	input  logic                start,
	input  julia_pkg::coord_t   job_re,
	input  julia_pkg::coord_t   job_im,
	input  julia_pkg::address_t job_addr,
	input  julia_pkg::coord_t   c_re,
	input  julia_pkg::coord_t   c_im,
	input  logic                grant,
	output logic                idle,
	output logic                done,
	output julia_pkg::address_t address,
	output julia_pkg::pixel_t   pixel
);

	// 4.0 at the scale of a shifted product
	localparam julia_pkg::wide_t ESCAPE = 32'sd4 <<< `JULIA_FRAC_BITS;

	julia_pkg::worker_state_t state;
	julia_pkg::coord_t z_re;
	julia_pkg::coord_t z_im;
	julia_pkg::pixel_t count;
	julia_pkg::wide_t re_sq;
	julia_pkg::wide_t im_sq;
	julia_pkg::wide_t re_im;
	julia_pkg::wide_t next_re;
	julia_pkg::wide_t next_im;
	logic load;
	logic escaped;
	logic stop;

	assign idle  = (state == julia_pkg::IDLE);
	assign done  = (state == julia_pkg::HOLD);
	assign pixel = count;
	assign load  = start && idle;

	// products back to Q4.12 by arithmetic shift
	always_comb begin
		re_sq   = (julia_pkg::wide_t'(z_re) * julia_pkg::wide_t'(z_re)) >>> `JULIA_FRAC_BITS;
		im_sq   = (julia_pkg::wide_t'(z_im) * julia_pkg::wide_t'(z_im)) >>> `JULIA_FRAC_BITS;
		re_im   = (julia_pkg::wide_t'(z_re) * julia_pkg::wide_t'(z_im)) >>> `JULIA_FRAC_BITS;
		// z^2 + c in real and imaginary parts
		next_re = re_sq - im_sq + julia_pkg::wide_t'(c_re);
		next_im = (re_im <<< 1) + julia_pkg::wide_t'(c_im);
	end

	// escape test runs on the current z before stepping
	assign escaped = (re_sq + im_sq) > ESCAPE;
	assign stop    = escaped || (count == julia_pkg::pixel_t'(`JULIA_MAX_ITER));

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= julia_pkg::IDLE;
		end else begin
			case (state)
				julia_pkg::IDLE:
					if (start)
						state <= julia_pkg::ITERATE;
				julia_pkg::ITERATE:
					if (stop)
						state <= julia_pkg::HOLD;
				// result held until search takes it
				julia_pkg::HOLD:
					if (grant)
						state <= julia_pkg::IDLE;
				default: state <= julia_pkg::IDLE;
			endcase
		end
	end

	// job registers step one iteration per cycle
	always_ff @(posedge clk) begin
		if (load) begin
			z_re    <= job_re;
			z_im    <= job_im;
			count   <= '0;
			address <= job_addr;
		end else if (state == julia_pkg::ITERATE && !stop) begin
			// truncate back to 16 bits
			z_re  <= next_re[15:0];
			z_im  <= next_im[15:0];
			count <= count + 1'b1;
		end
	end

endmodule

// File: verilog/pixel_dispatch.sv
`include "julia_config.svh"

module pixel_dispatch (
	input  logic                          clk,
	input  logic                          n_rst,
	input  logic                          frame_start,
	input  logic [`JULIA_NUM_JULIA-1:0]   idle,
	input  logic                          found,
	output logic [`JULIA_NUM_JULIA-1:0]   start,
	output julia_pkg::coord_t             job_re,
	output julia_pkg::coord_t             job_im,
	output julia_pkg::address_t           job_addr,
	output logic                          busy
);

	localparam int NUM_PIXELS = `JULIA_IMG_W * `JULIA_IMG_H;
	localparam int XW = $clog2(`JULIA_IMG_W + 1);
	localparam int YW = $clog2(`JULIA_IMG_H + 1);
	localparam int CW = $clog2(NUM_PIXELS + 1);

	julia_pkg::dispatch_state_t state;
	logic [XW-1:0] x;
	logic [YW-1:0] y;
	logic [CW-1:0] found_count;
	logic issue;
	logic last_x;
	logic last_y;
	logic last_found;

	assign last_x     = (x == XW'(`JULIA_IMG_W - 1));
	assign last_y     = (y == YW'(`JULIA_IMG_H - 1));
	assign last_found = (found_count == CW'(NUM_PIXELS - 1));
	assign busy       = (state != julia_pkg::WAIT_START);

	// lowest idle worker gets the job, one per cycle
	always_comb begin
		start = '0;
		issue = 1'b0;
		if (state == julia_pkg::ISSUE) begin
			for (int k = 0; k < `JULIA_NUM_JULIA; k++) begin
				if (idle[k] && !issue) begin
					start[k] = 1'b1;
					issue    = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state       <= julia_pkg::WAIT_START;
			x           <= '0;
			y           <= '0;
			found_count <= '0;
		end else begin
			// writes can land while still issuing
			if (busy && found)
				found_count <= found_count + 1'b1;
			case (state)
				julia_pkg::WAIT_START: begin
					if (frame_start) begin
						state       <= julia_pkg::ISSUE;
						x           <= '0;
						y           <= '0;
						found_count <= '0;
					end
				end
				julia_pkg::ISSUE: begin
					if (issue) begin
						if (last_x) begin
							x <= '0;
							if (last_y)
								state <= julia_pkg::DRAIN;
							else
								y <= y + 1'b1;
						end else begin
							x <= x + 1'b1;
						end
					end
				end
				julia_pkg::DRAIN: begin
					// frame over on the last write
					if (found && last_found)
						state <= julia_pkg::WAIT_START;
				end
				default: state <= julia_pkg::WAIT_START;
			endcase
		end
	end

	// plane coordinates accumulated alongside x and y
	always_ff @(posedge clk) begin
		if (state == julia_pkg::WAIT_START && frame_start) begin
			job_re   <= `JULIA_X0;
			job_im   <= `JULIA_Y0;
			job_addr <= '0;
		end else if (issue) begin
			job_addr <= job_addr + 1'b1;
			if (last_x) begin
				job_re <= `JULIA_X0;
				if (!last_y)
					job_im <= job_im + `JULIA_STEP;
			end else begin
				job_re <= job_re + `JULIA_STEP;
			end
		end
	end

endmodule

// File: verilog/julia_config_regs.sv
module julia_config_regs (
	input  logic                clk,
	input  logic                n_rst,
	input  logic                cfg_we,
	input  logic [1:0]          cfg_addr,
	input  logic [15:0]         cfg_wdata,
	input  logic                busy,
	output julia_pkg::coord_t   c_re,
	output julia_pkg::coord_t   c_im,
	output logic                frame_start
);

	logic blocked;

	// frame_start is high for one cycle before busy rises,
	// so that cycle is locked out too
	assign blocked = busy | frame_start;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			c_re        <= '0;
			c_im        <= '0;
			frame_start <= 1'b0;
		end else begin
			frame_start <= 1'b0;
			if (cfg_we && !blocked) begin
				case (cfg_addr)
					// real part of c
					2'd0: c_re <= julia_pkg::coord_t'(cfg_wdata);
					// imaginary part of c
					2'd1: c_im <= julia_pkg::coord_t'(cfg_wdata);
					// kick off one frame, data ignored
					2'd2: frame_start <= 1'b1;
					// address 3 unused
					default: ;
				endcase
			end
		end
	end

endmodule

// File: verilog/julia_pkg.sv
package julia_pkg;

	// Q4.12 value, used for c, z and job coordinates
	typedef logic signed [15:0] coord_t;

	// full product or sum before truncation
	typedef logic signed [31:0] wide_t;

	// frame buffer address, y*IMG_W + x
	typedef logic [31:0] address_t;

	// escape count written to the frame buffer
	typedef logic [7:0] pixel_t;

	// per-worker job state
	typedef enum logic [1:0] {
		IDLE,
		ITERATE,
		HOLD
	} worker_state_t;

	// frame walker state
	typedef enum logic [1:0] {
		WAIT_START,
		ISSUE,
		DRAIN
	} dispatch_state_t;

endpackage

// File: include/julia_config.svh
`ifndef JULIA_CONFIG_SVH
`define JULIA_CONFIG_SVH

// number of escape-time workers in the farm
`define JULIA_NUM_JULIA 4

// frame size in pixels
`define JULIA_IMG_W 8
`define JULIA_IMG_H 6

// escape count saturates here
`define JULIA_MAX_ITER 31

// Q4.12 fixed point, 16 bits signed
`define JULIA_FRAC_BITS 12

// plane coordinate of pixel (0,0): -1.5 and -1.0
`define JULIA_X0 16'shE800
`define JULIA_Y0 16'shF000

// plane step per pixel, 0.375
`define JULIA_STEP 16'sh0600

`endif
